// File: rtl/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Register map
`define UART_ADDR_DATA   3'd0
`define UART_ADDR_STATUS 3'd1
`define UART_ADDR_DIV    3'd2

// Depth must equal 2**AW
`define UART_FIFO_DEPTH 8
`define UART_FIFO_AW    3

// Clocks per bit
`define UART_DEFAULT_DIV 16'd16
`define UART_MIN_DIV     16'd4

`endif

// File: rtl/uart_pkg.sv
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

  typedef logic [2:0] uart_addr_t;
  typedef logic [7:0] uart_byte_t;
  typedef logic [15:0] uart_div_t;
  typedef logic [15:0] uart_word_t;
  typedef logic [`UART_FIFO_AW-1:0] uart_fifo_ptr_t;

  // Bus access sequencer
  typedef enum logic [2:0] {Idle, Read, Write, EndOp, Final} uart_fsm_state_t;

  // Serial frame states
  typedef enum logic [1:0] {TxIdle, TxStart, TxData, TxStop} uart_tx_state_t;
  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} uart_rx_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_fsm (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   rd_en,
  input  wire                   wr_en,
  input  wire uart_pkg::uart_addr_t addr,
  output logic                  op,
  output logic                  ack,
  output logic                  bank_rd_en,
  output logic                  bank_wr_en,
  output logic                  rxdata_wr_en,
  output logic                  tx_fifo_wr_en,
  output logic                  rx_fifo_rd_en
);

  uart_pkg::uart_fsm_state_t state;
  uart_pkg::uart_fsm_state_t next_state;
  logic is_data;

  // Data register is shared by the tx push and the rx pop
  assign is_data = (addr == `UART_ADDR_DATA);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= uart_pkg::Idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = uart_pkg::Idle;
    case (state)
      uart_pkg::Idle: begin
        if (rd_en) begin
          next_state = uart_pkg::Read;
        end else if (wr_en) begin
          next_state = uart_pkg::Write;
        end
      end
      uart_pkg::Read, uart_pkg::Write: begin
        if (is_data) begin
          next_state = uart_pkg::EndOp;
        end else begin
          next_state = uart_pkg::Final;
        end
      end
      uart_pkg::EndOp: next_state = uart_pkg::Final;
      default: next_state = uart_pkg::Idle;
    endcase
  end

  // Outputs registered from the next state
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      op            <= 1'b0;
      ack           <= 1'b0;
      bank_rd_en    <= 1'b0;
      bank_wr_en    <= 1'b0;
      rxdata_wr_en  <= 1'b0;
      tx_fifo_wr_en <= 1'b0;
    end else begin
      op            <= 1'b0;
      ack           <= 1'b0;
      bank_rd_en    <= 1'b0;
      bank_wr_en    <= 1'b0;
      rxdata_wr_en  <= 1'b0;
      tx_fifo_wr_en <= 1'b0;
      case (next_state)
        uart_pkg::Read: begin
          op         <= 1'b1;
          bank_rd_en <= 1'b1;
        end
        uart_pkg::Write: begin
          op         <= 1'b1;
          bank_wr_en <= 1'b1;
        end
        uart_pkg::EndOp: begin
          op            <= 1'b1;
          rxdata_wr_en  <= bank_rd_en & is_data;
          tx_fifo_wr_en <= bank_wr_en & is_data;
        end
        uart_pkg::Final: ack <= 1'b1;
        default: ;
      endcase
    end
  end

  // Pop in the Read cycle so rd_data is ready for EndOp
  assign rx_fifo_rd_en = bank_rd_en & is_data;

endmodule

`default_nettype wire

// File: rtl/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_regs (
  input  wire                   clock,
  input  wire                   reset,
  input  wire uart_pkg::uart_addr_t addr,
  input  wire uart_pkg::uart_word_t wdata,
  input  wire                   bank_rd_en,
  input  wire                   bank_wr_en,
  input  wire                   rxdata_wr_en,
  input  wire uart_pkg::uart_byte_t rx_data,
  input  wire                   tx_empty,
  input  wire                   tx_full,
  input  wire                   rx_empty,
  input  wire                   rx_full,
  input  wire                   tx_busy,
  input  wire                   rx_overrun,
  output uart_pkg::uart_word_t  rdata,
  output uart_pkg::uart_div_t   divisor
);

  logic overrun_flag;
  logic status_rd;
  uart_pkg::uart_word_t status;

  assign status_rd = bank_rd_en && (addr == `UART_ADDR_STATUS);

  assign status = {10'b0, tx_busy, overrun_flag, rx_full, rx_empty, tx_full, tx_empty};

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      divisor <= `UART_DEFAULT_DIV;
    end else if (bank_wr_en && (addr == `UART_ADDR_DIV)) begin
      // Clamp so the receiver always has a usable half period
      if (wdata < `UART_MIN_DIV) begin
        divisor <= `UART_MIN_DIV;
      end else begin
        divisor <= wdata;
      end
    end
  end

  // A new overrun wins over a clear in the same cycle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      overrun_flag <= 1'b0;
    end else if (rx_overrun) begin
      overrun_flag <= 1'b1;
    end else if (status_rd) begin
      overrun_flag <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rxdata_wr_en) begin
      rdata <= {8'h00, rx_data};
    end else if (bank_rd_en && (addr != `UART_ADDR_DATA)) begin
      case (addr)
        `UART_ADDR_STATUS: rdata <= status;
        `UART_ADDR_DIV:    rdata <= divisor;
        default:           rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_fifo (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   wr_en,
  input  wire uart_pkg::uart_byte_t wr_data,
  input  wire                   rd_en,
  output uart_pkg::uart_byte_t  rd_data,
  output logic                  empty,
  output logic                  full
);

  uart_pkg::uart_byte_t mem [`UART_FIFO_DEPTH];
  uart_pkg::uart_fifo_ptr_t wr_ptr;
  uart_pkg::uart_fifo_ptr_t rd_ptr;
  logic wr_wrap;
  logic rd_wrap;
  logic push;
  logic pop;

  // Wrap bits tell full from empty when the pointers meet
  assign empty = (wr_ptr == rd_ptr) && (wr_wrap == rd_wrap);
  assign full  = (wr_ptr == rd_ptr) && (wr_wrap != rd_wrap);

  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr  <= '0;
      wr_wrap <= 1'b0;
      rd_ptr  <= '0;
      rd_wrap <= 1'b0;
    end else begin
      if (push) begin
        {wr_wrap, wr_ptr} <= {wr_wrap, wr_ptr} + 1'b1;
      end
      if (pop) begin
        {rd_wrap, rd_ptr} <= {rd_wrap, rd_ptr} + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
    if (pop) begin
      rd_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire                   clock,
  input  wire                   reset,
  input  wire uart_pkg::uart_div_t divisor,
  input  wire                   fifo_empty,
  input  wire uart_pkg::uart_byte_t fifo_data,
  output logic                  fifo_rd_en,
  output logic                  txd,
  output logic                  busy
);

  uart_pkg::uart_tx_state_t state;
  uart_pkg::uart_div_t bit_div;
  uart_pkg::uart_div_t count;
  uart_pkg::uart_byte_t shift;
  logic [2:0] bit_idx;
  logic bit_end;

  assign bit_end    = (count == bit_div - 16'd1);
  assign fifo_rd_en = (state == uart_pkg::TxIdle) && !fifo_empty;
  assign busy       = (state != uart_pkg::TxIdle) || fifo_rd_en;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= uart_pkg::TxIdle;
      bit_div <= '0;
      count   <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      count <= count + 16'd1;
      case (state)
        uart_pkg::TxIdle: begin
          count <= '0;
          if (!fifo_empty) begin
            state   <= uart_pkg::TxStart;
            bit_div <= divisor;
            txd     <= 1'b0;
          end
        end
        uart_pkg::TxStart: begin
          if (bit_end) begin
            state   <= uart_pkg::TxData;
            count   <= '0;
            bit_idx <= '0;
            txd     <= shift[0];
          end
        end
        uart_pkg::TxData: begin
          if (bit_end) begin
            count <= '0;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::TxStop;
              txd   <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              txd     <= shift[1];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= uart_pkg::TxIdle;
          end
        end
      endcase
    end
  end

  // Byte arrives one cycle after the pop
  always_ff @(posedge clock) begin
    if (state == uart_pkg::TxStart && count == '0) begin
      shift <= fifo_data;
    end else if (state == uart_pkg::TxData && bit_end) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire                   clock,
  input  wire                   reset,
  input  wire uart_pkg::uart_div_t divisor,
  input  wire                   rxd,
  input  wire                   fifo_full,
  output logic                  fifo_wr_en,
  output uart_pkg::uart_byte_t  fifo_data,
  output logic                  overrun
);

  uart_pkg::uart_rx_state_t state;
  uart_pkg::uart_div_t bit_div;
  uart_pkg::uart_div_t count;
  uart_pkg::uart_byte_t shift;
  logic [2:0] bit_idx;
  logic rxd_meta;
  logic rxd_sync;
  logic bit_end;
  logic half_end;

  assign bit_end  = (count == bit_div - 16'd1);
  assign half_end = (count == (bit_div >> 1) - 16'd1);
  assign fifo_data = shift;

  // Line idles high
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= uart_pkg::RxIdle;
      bit_div    <= '0;
      count      <= '0;
      bit_idx    <= '0;
      fifo_wr_en <= 1'b0;
      overrun    <= 1'b0;
    end else begin
      count      <= count + 16'd1;
      fifo_wr_en <= 1'b0;
      overrun    <= 1'b0;
      case (state)
        uart_pkg::RxIdle: begin
          count <= '0;
          if (!rxd_sync) begin
            state   <= uart_pkg::RxStart;
            bit_div <= divisor;
          end
        end
        uart_pkg::RxStart: begin
          // Glitch shorter than half a bit goes back to idle
          if (half_end) begin
            count   <= '0;
            bit_idx <= '0;
            state   <= rxd_sync ? uart_pkg::RxIdle : uart_pkg::RxData;
          end
        end
        uart_pkg::RxData: begin
          if (bit_end) begin
            count   <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::RxStop;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= uart_pkg::RxIdle;
            if (rxd_sync) begin
              fifo_wr_en <= !fifo_full;
              overrun    <= fifo_full;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == uart_pkg::RxData && bit_end) begin
      shift <= {rxd_sync, shift[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   rd_en,
  input  wire                   wr_en,
  input  wire uart_pkg::uart_addr_t addr,
  input  wire uart_pkg::uart_word_t wdata,
  input  wire                   rxd,
  output uart_pkg::uart_word_t  rdata,
  output logic                  op,
  output logic                  ack,
  output logic                  txd
);

  logic bank_rd_en;
  logic bank_wr_en;
  logic rxdata_wr_en;
  logic tx_fifo_wr_en;
  logic rx_fifo_rd_en;
  logic tx_fifo_rd_en;
  logic rx_fifo_wr_en;
  logic tx_empty;
  logic tx_full;
  logic rx_empty;
  logic rx_full;
  logic tx_busy;
  logic rx_overrun;
  uart_pkg::uart_div_t divisor;
  uart_pkg::uart_byte_t tx_byte;
  uart_pkg::uart_byte_t rx_byte;
  uart_pkg::uart_byte_t rx_fifo_data;

  uart_fsm u_fsm (
    .clock, .reset, .rd_en, .wr_en, .addr, .op, .ack,
    .bank_rd_en, .bank_wr_en, .rxdata_wr_en, .tx_fifo_wr_en, .rx_fifo_rd_en
  );

  uart_regs u_regs (
    .clock, .reset, .addr, .wdata, .bank_rd_en, .bank_wr_en, .rxdata_wr_en,
    .rx_data(rx_fifo_data), .tx_empty, .tx_full, .rx_empty, .rx_full,
    .tx_busy, .rx_overrun, .rdata, .divisor
  );

  // Transmit path
  uart_fifo tx_fifo (
    .clock, .reset, .wr_en(tx_fifo_wr_en), .wr_data(wdata[7:0]),
    .rd_en(tx_fifo_rd_en), .rd_data(tx_byte), .empty(tx_empty), .full(tx_full)
  );

  uart_tx u_tx (
    .clock, .reset, .divisor, .fifo_empty(tx_empty), .fifo_data(tx_byte),
    .fifo_rd_en(tx_fifo_rd_en), .txd, .busy(tx_busy)
  );

  // Receive path
  uart_rx u_rx (
    .clock, .reset, .divisor, .rxd, .fifo_full(rx_full),
    .fifo_wr_en(rx_fifo_wr_en), .fifo_data(rx_byte), .overrun(rx_overrun)
  );

  uart_fifo rx_fifo (
    .clock, .reset, .wr_en(rx_fifo_wr_en), .wr_data(rx_byte),
    .rd_en(rx_fifo_rd_en), .rd_data(rx_fifo_data), .empty(rx_empty), .full(rx_full)
  );

endmodule

`default_nettype wire

// File: testbench/uart_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

// Sequencer and FIFO checks
module uart_props (
  input wire clock,
  input wire reset,
  input wire op,
  input wire ack,
  input wire bank_rd_en,
  input wire bank_wr_en,
  input wire wr_en,
  input wire rd_en,
  input wire full,
  input wire empty,
  input wire [`UART_FIFO_AW:0] wr_pos,
  input wire [`UART_FIFO_AW:0] rd_pos
);

  ack_without_op: assert property (@(posedge clock) disable iff (reset) !(ack && op))
    else $error("ack and op high together");

  one_bank_strobe: assert property (@(posedge clock) disable iff (reset)
    !(bank_rd_en && bank_wr_en))
    else $error("bank read and write strobes together");

  // Dropped push leaves the write pointer in place
  no_push_when_full: assert property (@(posedge clock) disable iff (reset)
    (full && wr_en) |=> (wr_pos == $past(wr_pos)))
    else $error("push accepted while full");

  no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
    (empty && rd_en) |=> (rd_pos == $past(rd_pos)))
    else $error("pop accepted while empty");

endmodule

bind uart_fsm uart_props fsm_props (
  .clock(clock), .reset(reset), .op(op), .ack(ack),
  .bank_rd_en(bank_rd_en), .bank_wr_en(bank_wr_en),
  .wr_en(1'b0), .rd_en(1'b0), .full(1'b0), .empty(1'b0),
  .wr_pos('0), .rd_pos('0)
);

bind uart_fifo uart_props fifo_props (
  .clock(clock), .reset(reset), .op(1'b0), .ack(1'b0),
  .bank_rd_en(1'b0), .bank_wr_en(1'b0),
  .wr_en(wr_en), .rd_en(rd_en), .full(full), .empty(empty),
  .wr_pos({wr_wrap, wr_ptr}), .rd_pos({rd_wrap, rd_ptr})
);

`default_nettype wire

// File: testbench/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_tb;

  localparam int clock_period = 40;
  localparam int frame_div = 16;
  localparam int total_frames = 17;
  // Twice the frame time of all tests
  localparam int watchdog_limit = 2 * total_frames * 10 * frame_div * clock_period;

  logic clock;
  logic reset;
  logic rd_en;
  logic wr_en;
  uart_pkg::uart_addr_t addr;
  uart_pkg::uart_word_t wdata;
  uart_pkg::uart_word_t rdata;
  logic op;
  logic ack;
  logic txd;
  logic rxd;
  logic loopback;
  integer seed;

  // Serial line closes on itself unless the testbench holds it idle
  assign rxd = loopback ? txd : 1'b1;

  uart_top DUT (
    .clock, .reset, .rd_en, .wr_en, .addr, .wdata, .rxd,
    .rdata, .op, .ack, .txd
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_limit);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $fatal(1, "watchdog timeout");
  end

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  // Strobe once and wait for ack while tracking op and latency
  task automatic bus_access(input logic write, input uart_pkg::uart_addr_t a,
                            input uart_pkg::uart_word_t d,
                            output uart_pkg::uart_word_t q);
    int cycles;
    int expected_cycles;
    expected_cycles = (a == `UART_ADDR_DATA) ? 3 : 2;
    @(posedge clock);
    #1;
    addr = a;
    wdata = d;
    rd_en = !write;
    wr_en = write;
    @(posedge clock);
    #1;
    rd_en = 1'b0;
    wr_en = 1'b0;
    cycles = 1;
    while (!ack) begin
      check("op", op, 1);
      if (cycles >= 8) begin
        abort_run($sformatf("No ack for the access to address %0d", a));
      end
      @(posedge clock);
      #1;
      cycles++;
    end
    check("op", op, 0);
    check("ack latency", cycles, expected_cycles);
    q = rdata;
  endtask

  task automatic bus_write(input uart_pkg::uart_addr_t a, input uart_pkg::uart_word_t d);
    uart_pkg::uart_word_t unused;
    bus_access(1'b1, a, d, unused);
  endtask

  task automatic bus_read(input uart_pkg::uart_addr_t a, output uart_pkg::uart_word_t q);
    bus_access(1'b0, a, 16'h0000, q);
  endtask

  // Poll until the tx FIFO is empty and the transmitter idle
  task automatic wait_tx_drained(input int max_polls);
    uart_pkg::uart_word_t value;
    int polls;
    polls = 0;
    bus_read(`UART_ADDR_STATUS, value);
    while (!(value[0] && !value[5])) begin
      polls++;
      if (polls > max_polls) begin
        abort_run("Transmitter never drained its FIFO");
      end
      bus_read(`UART_ADDR_STATUS, value);
    end
    // One bit of margin for the last receive push
    repeat (frame_div) @(posedge clock);
  endtask

  task automatic reset_values();
    uart_pkg::uart_word_t value;
    check("ack", ack, 0);
    check("op", op, 0);
    check("txd", txd, 1);
    // tx empty and rx empty
    bus_read(`UART_ADDR_STATUS, value);
    check("status", value, 16'h0005);
    bus_read(`UART_ADDR_DIV, value);
    check("divisor", value, `UART_DEFAULT_DIV);
  endtask

  task automatic access_timing();
    uart_pkg::uart_word_t value;
    bus_read(3'd5, value);
    check("unmapped rdata", value, 16'h0000);
    bus_write(3'd7, 16'h1234);
    bus_read(`UART_ADDR_DIV, value);
    check("divisor", value, `UART_DEFAULT_DIV);
  endtask

  task automatic divisor_clamp();
    uart_pkg::uart_word_t value;
    bus_write(`UART_ADDR_DIV, 16'd20);
    bus_read(`UART_ADDR_DIV, value);
    check("divisor", value, 16'd20);
    bus_write(`UART_ADDR_DIV, 16'd1);
    bus_read(`UART_ADDR_DIV, value);
    check("divisor", value, `UART_MIN_DIV);
    bus_write(`UART_ADDR_DIV, 16'(frame_div));
    bus_read(`UART_ADDR_DIV, value);
    check("divisor", value, frame_div);
  endtask

  task automatic frame_shape();
    uart_pkg::uart_byte_t frame_byte;
    frame_byte = 8'hA5;
    loopback = 1'b0;
    bus_write(`UART_ADDR_DATA, {8'h00, frame_byte});
    // Start bit begins on the edge after ack
    // Each bit is sampled at its middle
    repeat (1 + frame_div / 2) @(posedge clock);
    #1;
    check("txd start", txd, 0);
    for (int i = 0; i < 8; i++) begin
      repeat (frame_div) @(posedge clock);
      #1;
      check("txd data", txd, frame_byte[i]);
    end
    repeat (frame_div) @(posedge clock);
    #1;
    check("txd stop", txd, 1);
    repeat (frame_div) @(posedge clock);
    #1;
    loopback = 1'b1;
  endtask

  task automatic loopback_order();
    uart_pkg::uart_byte_t sent [6];
    uart_pkg::uart_word_t value;
    for (int i = 0; i < 6; i++) begin
      sent[i] = 8'($random(seed));
      bus_write(`UART_ADDR_DATA, {8'h00, sent[i]});
    end
    wait_tx_drained(6 * 10 * frame_div);
    // tx empty, rx holding data
    bus_read(`UART_ADDR_STATUS, value);
    check("status", value, 16'h0001);
    for (int i = 0; i < 6; i++) begin
      bus_read(`UART_ADDR_DATA, value);
      check("rx byte", value, {8'h00, sent[i]});
    end
    bus_read(`UART_ADDR_STATUS, value);
    check("status", value, 16'h0005);
    // Pop on an empty FIFO keeps the last byte
    bus_read(`UART_ADDR_DATA, value);
    check("rx byte", value, {8'h00, sent[5]});
  endtask

  task automatic rx_overflow();
    uart_pkg::uart_byte_t kept [8];
    uart_pkg::uart_byte_t next_byte;
    uart_pkg::uart_word_t value;
    for (int i = 0; i < 10; i++) begin
      next_byte = 8'($random(seed));
      if (i < 8) begin
        kept[i] = next_byte;
      end
      bus_write(`UART_ADDR_DATA, {8'h00, next_byte});
      // Wait one frame plus a bit period for an idle line
      repeat (11 * frame_div) @(posedge clock);
    end
    // tx empty, rx full, overrun set
    bus_read(`UART_ADDR_STATUS, value);
    check("status", value, 16'h0019);
    bus_read(`UART_ADDR_STATUS, value);
    check("status", value, 16'h0009);
    for (int i = 0; i < 8; i++) begin
      bus_read(`UART_ADDR_DATA, value);
      check("rx byte", value, {8'h00, kept[i]});
    end
    bus_read(`UART_ADDR_STATUS, value);
    check("status", value, 16'h0005);
  endtask

  initial begin
    seed = 16932;
    rd_en = 1'b0;
    wr_en = 1'b0;
    addr = '0;
    wdata = '0;
    loopback = 1'b1;
    reset = 1'b1;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    reset_values();
    access_timing();
    divisor_clamp();
    frame_shape();
    loopback_order();
    rx_overflow();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_fsm.sv
rtl/uart_regs.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
testbench/uart_props.sv
testbench/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

.PHONY: sim clean
